// File: hdl/host_domain.sv
// Host-domain memory slice behind the crossbar port
// Credit-based request and response ports; requests reach L2 or the
// cache config window and responses come back in request order
`timescale 1ns/1ps

module host_domain
  import host_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS  = 8,
  parameter int unsigned L2_BANK_SIZE = 2048,
  parameter int unsigned REQ_DEPTH    = 4,
  parameter int unsigned RSP_DEPTH    = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  host_req_t req_i,
  output logic      req_credit_o,
  output logic      rsp_valid_o,
  output host_rsp_t rsp_o,
  input  logic      rsp_credit_i
);

  localparam int unsigned WORD_W = $clog2(NB_L2_BANKS) + $clog2(L2_BANK_SIZE);
  localparam int unsigned FREE_W = $clog2(RSP_DEPTH + 1);

  host_req_t         req_head;
  logic              req_empty;
  logic              req_pop;
  logic              l2_en;
  logic              l2_we;
  logic [WORD_W-1:0] l2_word;
  data_t             l2_wdata;
  data_t             l2_rdata;
  logic              cfg_en;
  logic              cfg_we;
  logic              cfg_mapped;
  cfg_sel_t          cfg_sel;
  data_t             cfg_wdata;
  data_t             cfg_rdata;
  logic [FREE_W-1:0] rsp_free;
  logic              rsp_push;
  host_rsp_t         rsp_next;

  host_fifo #(
    .DEPTH     ( REQ_DEPTH  ),
    .payload_t ( host_req_t )
  ) i_req_fifo (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .push_i  ( req_valid_i ),
    .data_i  ( req_i       ),
    .pop_i   ( req_pop     ),
    .data_o  ( req_head    ),
    .empty_o ( req_empty   ),
    .free_o  (             )
  );

  host_router #(
    .NB_L2_BANKS  ( NB_L2_BANKS  ),
    .L2_BANK_SIZE ( L2_BANK_SIZE ),
    .RSP_DEPTH    ( RSP_DEPTH    )
  ) i_router (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_empty_i  ( req_empty    ),
    .req_i        ( req_head     ),
    .req_pop_o    ( req_pop      ),
    .req_credit_o ( req_credit_o ),
    .l2_en_o      ( l2_en        ),
    .l2_we_o      ( l2_we        ),
    .l2_word_o    ( l2_word      ),
    .l2_wdata_o   ( l2_wdata     ),
    .l2_rdata_i   ( l2_rdata     ),
    .cfg_en_o     ( cfg_en       ),
    .cfg_we_o     ( cfg_we       ),
    .cfg_mapped_o ( cfg_mapped   ),
    .cfg_sel_o    ( cfg_sel      ),
    .cfg_wdata_o  ( cfg_wdata    ),
    .cfg_rdata_i  ( cfg_rdata    ),
    .rsp_free_i   ( rsp_free     ),
    .rsp_push_o   ( rsp_push     ),
    .rsp_o        ( rsp_next     )
  );

  l2_banks #(
    .NB_L2_BANKS  ( NB_L2_BANKS  ),
    .L2_BANK_SIZE ( L2_BANK_SIZE )
  ) i_l2_banks (
    .clk_i   ( clk_i    ),
    .en_i    ( l2_en    ),
    .we_i    ( l2_we    ),
    .word_i  ( l2_word  ),
    .wdata_i ( l2_wdata ),
    .rdata_o ( l2_rdata )
  );

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .en_i     ( cfg_en     ),
    .we_i     ( cfg_we     ),
    .mapped_i ( cfg_mapped ),
    .sel_i    ( cfg_sel    ),
    .wdata_i  ( cfg_wdata  ),
    .rdata_o  ( cfg_rdata  )
  );

  rsp_issue #(
    .RSP_DEPTH ( RSP_DEPTH )
  ) i_rsp_issue (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .push_i       ( rsp_push     ),
    .rsp_i        ( rsp_next     ),
    .free_o       ( rsp_free     ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rsp_credit_i ( rsp_credit_i )
  );

endmodule

// File: hdl/host_fifo.sv
// Synchronous circular-buffer FIFO with a generic payload type
// Serves the request queue and the response queue inside rsp_issue
`timescale 1ns/1ps

module host_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  input  logic                       pop_i,
  output payload_t                   data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Head is visible the cycle after its push
  assign data_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;

endmodule

// File: hdl/host_pkg.sv
// Shared types and address map for the host-domain memory slice
// Import wherever request/response words or map constants are needed
package host_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [2:0]  cfg_sel_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } host_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } host_rsp_t;

  // L2 window base; its size follows from the bank parameters
  localparam addr_t L2_BASE = 32'h1C00_0000;

  // Cache configuration window, 4 KiB
  localparam addr_t       CFG_BASE   = 32'h1A10_0000;
  localparam addr_t       CFG_SIZE   = 32'h0000_1000;
  localparam int unsigned CFG_WORD_W = $clog2(CFG_SIZE) - 2;

  // Word offsets inside the configuration window
  localparam cfg_sel_t CFG_OFF_CACHE_START = 3'd0;
  localparam cfg_sel_t CFG_OFF_CACHE_END   = 3'd1;
  localparam cfg_sel_t CFG_OFF_SPM_START   = 3'd2;

  // Read value of offsets with no register behind them
  localparam data_t CFG_DEAD_WORD = 32'hDEAD_F000;

endpackage

// File: hdl/host_router.sv
// Request router: pops the request queue, decodes the address map and
// issues to L2 or the cache config window, then pushes ordered responses.
// One request per cycle; the response is pushed the cycle after the pop.
`timescale 1ns/1ps

module host_router
  import host_pkg::*;
#(
  parameter  int unsigned NB_L2_BANKS  = 8,
  parameter  int unsigned L2_BANK_SIZE = 2048,
  parameter  int unsigned RSP_DEPTH    = 4,
  localparam int unsigned WORD_W       = $clog2(NB_L2_BANKS) + $clog2(L2_BANK_SIZE),
  localparam int unsigned FREE_W       = $clog2(RSP_DEPTH + 1)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_empty_i,
  input  host_req_t         req_i,
  output logic              req_pop_o,
  output logic              req_credit_o,
  output logic              l2_en_o,
  output logic              l2_we_o,
  output logic [WORD_W-1:0] l2_word_o,
  output data_t             l2_wdata_o,
  input  data_t             l2_rdata_i,
  output logic              cfg_en_o,
  output logic              cfg_we_o,
  output logic              cfg_mapped_o,
  output cfg_sel_t          cfg_sel_o,
  output data_t             cfg_wdata_o,
  input  data_t             cfg_rdata_i,
  input  logic [FREE_W-1:0] rsp_free_i,
  output logic              rsp_push_o,
  output host_rsp_t         rsp_o
);

  localparam addr_t L2_BYTES = addr_t'(NB_L2_BANKS * L2_BANK_SIZE * 4);

  addr_t                 l2_off;
  addr_t                 cfg_off;
  logic [CFG_WORD_W-1:0] cfg_word;
  logic                  hit_l2;
  logic                  hit_cfg;
  logic                  pop;
  logic                  s1_valid_q;
  logic                  s1_we_q;
  logic                  s1_cfg_q;
  logic                  s1_err_q;

  assign l2_off   = req_i.addr - L2_BASE;
  assign cfg_off  = req_i.addr - CFG_BASE;
  assign cfg_word = cfg_off[CFG_WORD_W+1:2];
  assign hit_l2   = (req_i.addr >= L2_BASE) && (l2_off < L2_BYTES);
  assign hit_cfg  = (req_i.addr >= CFG_BASE) && (cfg_off < CFG_SIZE);

  // Leave a slot for the response still sitting in the issue stage
  assign pop          = !req_empty_i && (rsp_free_i > FREE_W'(s1_valid_q));
  assign req_pop_o    = pop;
  assign req_credit_o = pop;

  assign l2_en_o    = pop && hit_l2;
  assign l2_we_o    = req_i.we;
  assign l2_word_o  = l2_off[WORD_W+1:2];
  assign l2_wdata_o = req_i.wdata;

  assign cfg_en_o     = pop && hit_cfg;
  assign cfg_we_o     = req_i.we;
  assign cfg_sel_o    = cfg_sel_t'(cfg_word);
  assign cfg_wdata_o  = req_i.wdata;
  assign cfg_mapped_o = (cfg_word == CFG_WORD_W'(CFG_OFF_CACHE_START)) ||
                        (cfg_word == CFG_WORD_W'(CFG_OFF_CACHE_END)) ||
                        (cfg_word == CFG_WORD_W'(CFG_OFF_SPM_START));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      s1_we_q  <= req_i.we;
      s1_cfg_q <= hit_cfg;
      s1_err_q <= !hit_l2 && !hit_cfg;
    end
  end

  // Writes and errors return zero data
  always_comb begin
    rsp_o = '0;
    if (s1_err_q) begin
      rsp_o.err = 1'b1;
    end else if (!s1_we_q) begin
      rsp_o.rdata = s1_cfg_q ? cfg_rdata_i : l2_rdata_i;
    end
  end

  assign rsp_push_o = s1_valid_q;

endmodule

// File: hdl/l2_banks.sv
// Word-interleaved L2 bank array, one-cycle read latency
// Low word-index bits select the bank, the remaining bits the row
`timescale 1ns/1ps

module l2_banks
  import host_pkg::*;
#(
  parameter  int unsigned NB_L2_BANKS  = 8,
  parameter  int unsigned L2_BANK_SIZE = 2048,
  localparam int unsigned BANK_W       = $clog2(NB_L2_BANKS),
  localparam int unsigned ROW_W        = $clog2(L2_BANK_SIZE),
  localparam int unsigned WORD_W       = BANK_W + ROW_W
) (
  input  logic              clk_i,
  input  logic              en_i,
  input  logic              we_i,
  input  logic [WORD_W-1:0] word_i,
  input  data_t             wdata_i,
  output data_t             rdata_o
);

  logic [BANK_W-1:0] bank;
  logic [ROW_W-1:0]  row;
  logic [BANK_W-1:0] bank_sel_q;
  data_t             bank_rdata [NB_L2_BANKS];

  assign bank = word_i[BANK_W-1:0];
  assign row  = word_i[WORD_W-1:BANK_W];

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    data_t mem [L2_BANK_SIZE];
    logic  bank_en;

    assign bank_en = en_i && (bank == BANK_W'(b));

    // Power-up contents are zero
    initial begin
      for (int i = 0; i < L2_BANK_SIZE; i++) begin
        mem[i] = '0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (we_i) begin
          mem[row] <= wdata_i;
        end else begin
          bank_rdata[b] <= mem[row];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      bank_sel_q <= bank;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule

// File: hdl/llc_cfg_regs.sv
// Last-level-cache configuration registers for builds without the cache
// Holds cached start/end and scratchpad start; unmapped offsets read the
// dead word and ignore writes. Read data follows one cycle after en_i.
`timescale 1ns/1ps

module llc_cfg_regs
  import host_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  logic     we_i,
  input  logic     mapped_i,
  input  cfg_sel_t sel_i,
  input  data_t    wdata_i,
  output data_t    rdata_o
);

  data_t cache_start_q;
  data_t cache_end_q;
  data_t spm_start_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
    end else if (en_i && we_i && mapped_i) begin
      case (sel_i)
        CFG_OFF_CACHE_START: cache_start_q <= wdata_i;
        CFG_OFF_CACHE_END:   cache_end_q   <= wdata_i;
        CFG_OFF_SPM_START:   spm_start_q   <= wdata_i;
        default:             cache_start_q <= cache_start_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      if (!mapped_i) begin
        rdata_o <= CFG_DEAD_WORD;
      end else begin
        case (sel_i)
          CFG_OFF_CACHE_START: rdata_o <= cache_start_q;
          CFG_OFF_CACHE_END:   rdata_o <= cache_end_q;
          CFG_OFF_SPM_START:   rdata_o <= spm_start_q;
          default:             rdata_o <= CFG_DEAD_WORD;
        endcase
      end
    end
  end

endmodule

// File: hdl/rsp_issue.sv
// Response queue with credit-gated issue toward the consumer
// One response per cycle while credits remain; rsp_credit_i returns one
`timescale 1ns/1ps

module rsp_issue
  import host_pkg::*;
#(
  parameter  int unsigned RSP_DEPTH = 4,
  localparam int unsigned CNT_W     = $clog2(RSP_DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  host_rsp_t        rsp_i,
  output logic [CNT_W-1:0] free_o,
  output logic             rsp_valid_o,
  output host_rsp_t        rsp_o,
  input  logic             rsp_credit_i
);

  logic             empty;
  logic [CNT_W-1:0] credit_q;

  host_fifo #(
    .DEPTH     ( RSP_DEPTH  ),
    .payload_t ( host_rsp_t )
  ) i_rsp_fifo (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .push_i  ( push_i      ),
    .data_i  ( rsp_i       ),
    .pop_i   ( rsp_valid_o ),
    .data_o  ( rsp_o       ),
    .empty_o ( empty       ),
    .free_o  ( free_o      )
  );

  assign rsp_valid_o = !empty && (credit_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= CNT_W'(RSP_DEPTH);
    end else begin
      case ({rsp_credit_i, rsp_valid_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// File: host_domain.f
hdl/host_pkg.sv
hdl/host_fifo.sv
hdl/l2_banks.sv
hdl/llc_cfg_regs.sv
hdl/rsp_issue.sv
hdl/host_router.sv
hdl/host_domain.sv
sim/host_domain_sva.sv
sim/tb_host_domain.sv

// File: run.sh
#!/bin/sh
# Build the host_domain testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_host_domain \
  -f host_domain.f -o tb_host_domain &&
  out=$(./obj_dir/tb_host_domain 2>&1)
echo "$out"
echo "$out" | grep -q "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/host_domain_sva.sv
// Concurrent checks on the host_domain ports
// Bound into every host_domain instance from this file
`timescale 1ns/1ps

module host_domain_sva
  import host_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      req_credit_o,
  input logic      rsp_valid_o,
  input host_rsp_t rsp_o
);

  // Quiet outputs once reset has been seen on a clock edge
  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_n_i && $past(!rst_n_i) |-> !req_credit_o && !rsp_valid_o)
    else $error("credit or response output active during reset");

  a_err_zero_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && rsp_o.err |-> rsp_o.rdata == '0)
    else $error("error response carries nonzero data %h", rsp_o.rdata);

  a_rsp_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> !$isunknown(rsp_o))
    else $error("response word has unknown bits while valid");

endmodule

bind host_domain host_domain_sva i_host_domain_sva (
  .clk_i        ( clk_i        ),
  .rst_n_i      ( rst_n_i      ),
  .req_credit_o ( req_credit_o ),
  .rsp_valid_o  ( rsp_valid_o  ),
  .rsp_o        ( rsp_o        )
);

// File: sim/tb_host_domain.sv
// Testbench for host_domain with random credit-respecting traffic to L2,
// the cache config window and unmapped space, checked in request order
// against a behavioral model of the address map
`timescale 1ns/1ps

module tb_host_domain
  import host_pkg::*;
();

  localparam int unsigned NB_L2_BANKS  = 8;
  localparam int unsigned L2_BANK_SIZE = 2048;
  localparam int unsigned REQ_DEPTH    = 4;
  localparam int unsigned RSP_DEPTH    = 4;
  localparam int unsigned NUM_REQ      = 400;
  localparam int unsigned MAX_CYCLES   = NUM_REQ * 40;
  localparam addr_t       L2_BYTES     = addr_t'(NB_L2_BANKS * L2_BANK_SIZE * 4);
  localparam addr_t       CFG_BYTES    = 32'h0000_1000;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_valid_i;
  host_req_t req_i;
  logic      req_credit_o;
  logic      rsp_valid_o;
  host_rsp_t rsp_o;
  logic      rsp_credit_i;

  data_t       l2_model [int unsigned];
  data_t       cfg_model [3];
  host_rsp_t   exp_q [$];
  int unsigned sent;
  int unsigned received;
  int unsigned cycles;
  int unsigned req_credits;
  int unsigned rsp_credits;
  int unsigned rsp_owed;
  int unsigned hold;
  logic        give;

  host_domain #(
    .NB_L2_BANKS  ( NB_L2_BANKS  ),
    .L2_BANK_SIZE ( L2_BANK_SIZE ),
    .REQ_DEPTH    ( REQ_DEPTH    ),
    .RSP_DEPTH    ( RSP_DEPTH    )
  ) i_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_credit_o ( req_credit_o ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rsp_credit_i ( rsp_credit_i )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // Directed prelude first and a random mix of targets after it
  function automatic host_req_t make_req(int unsigned idx);
    host_req_t   req;
    int unsigned kind;
    req       = '0;
    req.wdata = $urandom;
    kind      = $urandom % 16;
    req.we    = ($urandom % 2) == 1;
    if (idx < 16) begin
      // Consecutive words over every bank
      req.we   = 1'b1;
      req.addr = L2_BASE + addr_t'(idx * 4);
    end else if (idx < 32) begin
      req.we   = 1'b0;
      req.addr = L2_BASE + addr_t'((idx - 16) * 4);
    end else if (idx < 44) begin
      // Read reset values, write and read back offsets 0, 1, 2 and the unmapped 8
      req.we   = (idx >= 36) && (idx < 40);
      req.addr = CFG_BASE + addr_t'((((idx % 4) == 3) ? 8 : (idx % 4)) * 4);
    end else if (idx == 44) begin
      req.we   = 1'b0;
      req.addr = L2_BASE + addr_t'(1000 * 4);
    end else if (idx == 45) begin
      req.we   = 1'b1;
      req.addr = L2_BASE + L2_BYTES;
    end else if (idx == 46) begin
      req.we   = 1'b0;
      req.addr = 32'h0000_0000;
    end else if (kind < 11) begin
      req.addr = L2_BASE + addr_t'(($urandom % 64) * 4);
    end else if (kind < 14) begin
      req.addr = CFG_BASE + addr_t'(($urandom % 12) * 4);
    end else begin
      // Just past the end of either window
      req.addr = ((kind == 14) ? (L2_BASE + L2_BYTES) : (CFG_BASE + CFG_BYTES)) +
                 addr_t'(($urandom % 64) * 4);
    end
    return req;
  endfunction

  function automatic host_rsp_t model_rsp(host_req_t req);
    host_rsp_t   rsp;
    int unsigned word;
    rsp = '0;
    if (req.addr >= L2_BASE && req.addr < L2_BASE + L2_BYTES) begin
      word = (req.addr - L2_BASE) >> 2;
      if (req.we) begin
        l2_model[word] = req.wdata;
      end else if (l2_model.exists(word)) begin
        rsp.rdata = l2_model[word];
      end
    end else if (req.addr >= CFG_BASE && req.addr < CFG_BASE + CFG_BYTES) begin
      word = (req.addr - CFG_BASE) >> 2;
      if (word < 3) begin
        if (req.we) begin
          cfg_model[word] = req.wdata;
        end else begin
          rsp.rdata = cfg_model[word];
        end
      end else if (!req.we) begin
        rsp.rdata = CFG_DEAD_WORD;
      end
    end else begin
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_rsp(host_rsp_t got, host_rsp_t exp);
    if (got.rdata !== exp.rdata) begin
      abort_run($sformatf("Fail rsp_o.rdata got %h exp %h", got.rdata, exp.rdata));
    end else if (got.err !== exp.err) begin
      abort_run($sformatf("Fail rsp_o.err got %h exp %h", got.err, exp.err));
    end
  endtask

  initial begin
    void'($urandom(98));
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_credit_i = 1'b0;
    rst_n_i      = 1'b0;
    cfg_model    = '{default: '0};
    sent         = 0;
    received     = 0;
    cycles       = 0;
    req_credits  = REQ_DEPTH;
    rsp_credits  = RSP_DEPTH;
    rsp_owed     = 0;
    hold         = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    while (received < NUM_REQ && cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      #1;
      cycles++;
      req_valid_i = 1'b0;
      if (sent < NUM_REQ && req_credits > 0 && ($urandom % 4) != 0) begin
        req_i = make_req(sent);
        exp_q.push_back(model_rsp(req_i));
        req_valid_i = 1'b1;
        req_credits--;
        sent++;
      end
      // Return consumed-response credits but hold them back in bursts
      if (hold > 0) begin
        hold--;
      end else if (($urandom % 32) == 0) begin
        hold = 10 + $urandom % 30;
      end
      give = (hold == 0) && (rsp_owed > 0) && (($urandom % 3) != 0);
      rsp_credit_i = give;
      if (give) begin
        rsp_owed--;
      end

      @(negedge clk_i);
      if (req_credit_o) begin
        req_credits++;
        if (req_credits > REQ_DEPTH) begin
          abort_run("More request credits came back than requests were sent");
        end
      end
      if (rsp_valid_o) begin
        if (rsp_credits == 0) begin
          abort_run("A response was issued while no response credit was held");
        end else if (exp_q.size() == 0) begin
          abort_run("A response arrived with no request outstanding");
        end
        rsp_credits--;
        rsp_owed++;
        received++;
        check_rsp(rsp_o, exp_q.pop_front());
      end
      if (give) begin
        rsp_credits++;
      end
    end

    if (received == NUM_REQ) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Timeout: responses stopped arriving, %0d of %0d received", received, NUM_REQ);
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule
